//--- verilog/frame_pkg.sv
`default_nettype none

package frame_pkg;

    // Write side FSM of the window writer
    typedef enum logic [1:0] {
        wr_idle,  // Waiting for din_sop
        wr_frame, // Capturing the input frame
        wr_swap   // Frame stored, swap_req raised
    } wr_state_e;

    // Index of one of the two ping-pong banks
    typedef logic bank_t;

endpackage

`default_nettype wire

//--- verilog/scan_pkg.sv
`default_nettype none

package scan_pkg;

    typedef enum logic [1:0] {
        sw_wait,    // No swap request seen
        sw_ack,     // Ack raised and display bank flipped
        sw_release  // Holding ack until req falls
    } sw_state_e;

    // Vertical phase of the raster
    typedef enum logic [1:0] {
        scan_active,
        scan_blank
    } scan_phase_e;

endpackage

`default_nettype wire

//--- verilog/pixel_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface pixel_mem_if #(
    parameter int ADDR_W = 6
);
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic              wr_data;
    frame_pkg::bank_t  wr_bank;  // Bank the writer fills
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    frame_pkg::bank_t  rd_bank;  // Bank on display
    logic              rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data, wr_bank
    );

    modport reader (
        output rd_en, rd_addr, rd_bank,
        input  rd_data
    );

    modport memory (
        input  wr_en, wr_addr, wr_data, wr_bank, rd_en, rd_addr, rd_bank,
        output rd_data
    );
endinterface

`default_nettype wire

//--- verilog/window_writer.sv
`timescale 1ns/1ps
`default_nettype none

module window_writer #(
    parameter int IMG_W  = 16,
    parameter int IMG_H  = 12,
    parameter int WIN_X  = 4,
    parameter int WIN_Y  = 3,
    parameter int WIN_W  = 8,
    parameter int WIN_H  = 6,
    parameter int ADDR_W = 6
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        din,
    input  logic        din_vld,
    input  logic        din_sop,
    input  logic        din_eop,
    pixel_mem_if.writer mem,
    output logic        swap_req,
    input  logic        swap_ack
);

    localparam int CW = $clog2(IMG_W);
    localparam int RW = $clog2(IMG_H);

    frame_pkg::wr_state_e state;
    logic [CW-1:0]        col;
    logic [RW-1:0]        row;
    logic                 accept;
    logic                 last_pix;
    logic                 frame_end;
    logic                 in_win;
    logic [ADDR_W-1:0]    win_addr;

    // A frame starts only from idle, so a sop during wr_swap drops that frame
    assign accept = din_vld && (state == frame_pkg::wr_frame ||
                                (state == frame_pkg::wr_idle && din_sop));
    assign last_pix = (col == CW'(IMG_W - 1)) && (row == RW'(IMG_H - 1));
    assign frame_end = accept && (last_pix || din_eop); // An early eop also closes the frame

    assign in_win = (col >= WIN_X) && (col < WIN_X + WIN_W) &&
                    (row >= WIN_Y) && (row < WIN_Y + WIN_H);
    assign win_addr = ADDR_W'((row - WIN_Y) * WIN_W + (col - WIN_X));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (frame_end) begin
            col <= '0;
            row <= '0;
        end else if (accept) begin
            if (col == CW'(IMG_W - 1)) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= frame_pkg::wr_idle;
            swap_req    <= 1'b0;
            mem.wr_bank <= 1'b0;
        end else begin
            case (state)
                frame_pkg::wr_idle, frame_pkg::wr_frame: begin
                    if (frame_end) begin
                        state    <= frame_pkg::wr_swap;
                        swap_req <= 1'b1;
                    end else if (accept) begin
                        state <= frame_pkg::wr_frame;
                    end
                end
                frame_pkg::wr_swap: begin
                    if (swap_ack) begin
                        state       <= frame_pkg::wr_idle;
                        swap_req    <= 1'b0;
                        mem.wr_bank <= ~mem.wr_bank; // Take over the bank just released by the reader
                    end
                end
                default: state <= frame_pkg::wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.wr_en <= 1'b0;
        end else begin
            mem.wr_en <= accept && in_win;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && in_win) begin
            mem.wr_addr <= win_addr;
            mem.wr_data <= din;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pingpong_ram.sv
`timescale 1ns/1ps
`default_nettype none

module pingpong_ram #(
    parameter int ADDR_W = 6
) (
    input  logic        clk,
    pixel_mem_if.memory mem
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic store [2][DEPTH]; // First index is the bank

    // Display bank starts out blank
    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int a = 0; a < DEPTH; a++) begin
                store[b][a] = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (mem.wr_en) begin
            store[mem.wr_bank][mem.wr_addr] <= mem.wr_data;
        end
    end

    // Registered read that holds its value while rd_en is low
    always @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= store[mem.rd_bank][mem.rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/scan_reader.sv
`timescale 1ns/1ps
`default_nettype none

module scan_reader #(
    parameter int WIN_W   = 8,
    parameter int WIN_H   = 6,
    parameter int H_BLANK = 4,
    parameter int V_BLANK = 2,
    parameter int ADDR_W  = 6
) (
    input  logic        clk,
    input  logic        rst_n,
    pixel_mem_if.reader mem,
    input  logic        swap_req,
    output logic        swap_ack,
    output logic        vga_hs,
    output logic        vga_vs,
    output logic        vga_de,
    output logic        vga_pix
);

    localparam int LINE_LEN    = WIN_W + H_BLANK;
    localparam int FRAME_LINES = WIN_H + V_BLANK;
    localparam int HW          = $clog2(LINE_LEN);
    localparam int VW          = $clog2(FRAME_LINES);

    logic [HW-1:0]          h_cnt;
    logic [VW-1:0]          v_cnt;
    scan_pkg::scan_phase_e  phase;
    scan_pkg::sw_state_e    sw_state;
    frame_pkg::bank_t       disp_bank;
    logic [ADDR_W-1:0]      addr_cnt;
    logic                   line_end;
    logic                   frame_last;
    logic                   blank_start;
    logic                   active;
    logic                   hs_raw;
    logic                   vs_raw;
    logic                   de_d1;
    logic                   hs_d1;
    logic                   vs_d1;

    assign line_end    = h_cnt == HW'(LINE_LEN - 1);
    assign frame_last  = v_cnt == VW'(FRAME_LINES - 1);
    assign blank_start = line_end && v_cnt == VW'(WIN_H - 1);
    assign active      = phase == scan_pkg::scan_active && h_cnt < WIN_W;
    assign hs_raw      = !(h_cnt >= WIN_W && h_cnt < WIN_W + H_BLANK - 2);
    assign vs_raw      = !(phase == scan_pkg::scan_blank && v_cnt == VW'(WIN_H));

    assign mem.rd_en   = active;
    assign mem.rd_addr = addr_cnt;
    assign mem.rd_bank = disp_bank;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
            phase <= scan_pkg::scan_active;
        end else begin
            h_cnt <= line_end ? '0 : h_cnt + 1'b1;
            if (line_end) begin
                v_cnt <= frame_last ? '0 : v_cnt + 1'b1;
            end
            if (blank_start) begin
                phase <= scan_pkg::scan_blank;
            end else if (line_end && frame_last) begin
                phase <= scan_pkg::scan_active;
            end
        end
    end

    // Linear window address, wraps after the last active pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt <= '0;
        end else if (active) begin
            addr_cnt <= (addr_cnt == ADDR_W'(WIN_W * WIN_H - 1)) ? '0 : addr_cnt + 1'b1;
        end
    end

    // Two stages to line up with the registered RAM read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_d1   <= 1'b0;
            hs_d1   <= 1'b1;
            vs_d1   <= 1'b1;
            vga_de  <= 1'b0;
            vga_hs  <= 1'b1;
            vga_vs  <= 1'b1;
            vga_pix <= 1'b0;
        end else begin
            de_d1   <= active;
            hs_d1   <= hs_raw;
            vs_d1   <= vs_raw;
            vga_de  <= de_d1;
            vga_hs  <= hs_d1;
            vga_vs  <= vs_d1;
            vga_pix <= de_d1 & mem.rd_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_state  <= scan_pkg::sw_wait;
            swap_ack  <= 1'b0;
            disp_bank <= 1'b1;
        end else begin
            case (sw_state)
                scan_pkg::sw_wait: begin
                    if (blank_start && swap_req) begin
                        sw_state  <= scan_pkg::sw_ack;
                        swap_ack  <= 1'b1;
                        disp_bank <= ~disp_bank; // Safe here since no reads happen in blank
                    end
                end
                scan_pkg::sw_ack: sw_state <= scan_pkg::sw_release;
                scan_pkg::sw_release: begin
                    if (!swap_req) begin
                        sw_state <= scan_pkg::sw_wait;
                        swap_ack <= 1'b0;
                    end
                end
                default: sw_state <= scan_pkg::sw_wait;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/frame_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module frame_display_top #(
    parameter int IMG_W   = 16,
    parameter int IMG_H   = 12,
    parameter int WIN_X   = 4,
    parameter int WIN_Y   = 3,
    parameter int WIN_W   = 8,
    parameter int WIN_H   = 6,
    parameter int H_BLANK = 4,
    parameter int V_BLANK = 2,
    parameter int ADDR_W  = 6  // Must cover WIN_W * WIN_H
) (
    input  logic clk,
    input  logic rst_n,
    input  logic din,
    input  logic din_vld,
    input  logic din_sop,
    input  logic din_eop,
    output logic vga_hs,
    output logic vga_vs,
    output logic vga_de,
    output logic vga_pix,
    output logic frame_pending
);

    logic swap_req;
    logic swap_ack;

    pixel_mem_if #(.ADDR_W(ADDR_W)) mem_bus ();

    assign frame_pending = swap_req;

    window_writer #(
        .IMG_W(IMG_W), .IMG_H(IMG_H), .WIN_X(WIN_X), .WIN_Y(WIN_Y),
        .WIN_W(WIN_W), .WIN_H(WIN_H), .ADDR_W(ADDR_W)
    ) u_writer (
        .clk(clk), .rst_n(rst_n),
        .din(din), .din_vld(din_vld), .din_sop(din_sop), .din_eop(din_eop),
        .mem(mem_bus.writer),
        .swap_req(swap_req), .swap_ack(swap_ack)
    );

    pingpong_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk(clk),
        .mem(mem_bus.memory)
    );

    scan_reader #(
        .WIN_W(WIN_W), .WIN_H(WIN_H), .H_BLANK(H_BLANK), .V_BLANK(V_BLANK),
        .ADDR_W(ADDR_W)
    ) u_reader (
        .clk(clk), .rst_n(rst_n),
        .mem(mem_bus.reader),
        .swap_req(swap_req), .swap_ack(swap_ack),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_de(vga_de), .vga_pix(vga_pix)
    );

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_NS = 5  // Half of the 10 ns period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- bench/tb_frame_display.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frame_display;

    localparam int IMG_W   = 16;
    localparam int IMG_H   = 12;
    localparam int WIN_X   = 4;
    localparam int WIN_Y   = 3;
    localparam int WIN_W   = 8;
    localparam int WIN_H   = 6;
    localparam int V_BLANK = 2;
    localparam int TIMEOUT = 2000;  // Clocks, several display frames

    logic   clk;
    logic   rst_n;
    logic   din;
    logic   din_vld;
    logic   din_sop;
    logic   din_eop;
    logic   vga_hs;
    logic   vga_vs;
    logic   vga_de;
    logic   vga_pix;
    logic   frame_pending;
    integer seed = 34821;
    int     errors = 0;
    int     checks = 0;
    bit     aborted = 1'b0;
    bit     img [IMG_H][IMG_W];
    bit     pend_win [WIN_H][WIN_W];  // Window of the frame waiting for its swap
    bit     shown_win [WIN_H][WIN_W];  // Window the display should show now

    clk_gen u_clk (.clk(clk));

    frame_display_top u_dut (
        .clk(clk), .rst_n(rst_n),
        .din(din), .din_vld(din_vld), .din_sop(din_sop), .din_eop(din_eop),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_de(vga_de), .vga_pix(vga_pix),
        .frame_pending(frame_pending)
    );

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_hit(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        aborted = 1'b1;  // Later waits return at once so the run can close
    endtask

    task automatic check_idle();
        check_val("frame_pending", frame_pending, 0);
        check_val("vga_de", vga_de, 0);
        check_val("vga_pix", vga_pix, 0);
        check_val("vga_hs", vga_hs, 1);
        check_val("vga_vs", vga_vs, 1);
    endtask

    // Random window, ones everywhere outside it so a leak shows up
    task automatic make_frame();
        int r;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                r = $random(seed);
                img[y][x] = (x >= WIN_X && x < WIN_X + WIN_W &&
                             y >= WIN_Y && y < WIN_Y + WIN_H) ? r[0] : 1'b1;
            end
        end
    endtask

    task automatic latch_window();
        for (int r = 0; r < WIN_H; r++) begin
            for (int c = 0; c < WIN_W; c++) begin
                pend_win[r][c] = img[WIN_Y + r][WIN_X + c];
            end
        end
    endtask

    task automatic send_frame(input bit gaps);
        int r;
        for (int y = 0; y < IMG_H; y++) begin
            for (int x = 0; x < IMG_W; x++) begin
                if (gaps) begin
                    r = $random(seed);
                    repeat (r[1:0]) begin
                        @(posedge clk);
                        din_vld <= 1'b0;
                        din_sop <= 1'b0;
                        din_eop <= 1'b0;
                    end
                end
                @(posedge clk);
                din     <= img[y][x];
                din_vld <= 1'b1;
                din_sop <= (x == 0) && (y == 0);
                din_eop <= (x == IMG_W - 1) && (y == IMG_H - 1);
            end
        end
        @(posedge clk);
        din_vld <= 1'b0;
        din_sop <= 1'b0;
        din_eop <= 1'b0;
    endtask

    task automatic wait_swap_done();
        int n;
        if (aborted) return;
        n = 0;
        @(negedge clk);
        while (frame_pending) begin
            if (n == TIMEOUT) begin
                timeout_hit("the bank swap to finish");
                return;
            end
            n++;
            @(negedge clk);
        end
        shown_win = pend_win;
    endtask

    task automatic wait_vs_fall();
        int   n;
        logic prev;
        if (aborted) return;
        n = 0;
        prev = vga_vs;
        @(negedge clk);
        while (!(prev && !vga_vs)) begin
            if (n == TIMEOUT) begin
                timeout_hit("a falling edge of vga_vs");
                return;
            end
            n++;
            prev = vga_vs;
            @(negedge clk);
        end
    endtask

    // Compares one display frame against the window of the last swapped frame
    task automatic capture_check();
        int n;
        int k;
        wait_vs_fall();
        if (aborted) return;
        n = 0;
        k = 0;
        while (k < WIN_W * WIN_H) begin
            if (n == TIMEOUT) begin
                timeout_hit("active display pixels");
                return;
            end
            if (vga_de) begin
                check_val($sformatf("vga_pix[%0d]", k), vga_pix,
                          shown_win[k / WIN_W][k % WIN_W]);
                k++;
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic show_frame(input bit gaps);
        make_frame();
        send_frame(gaps);
        latch_window();
        wait_swap_done();
        capture_check();
    endtask

    task automatic test_reset();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) rst_n <= 1'b1;
            @(negedge clk);
            check_idle();
        end
        @(negedge clk);
        check_idle();
        capture_check();  // Display bank is still blank
    endtask

    task automatic test_drop();
        make_frame();
        send_frame(1'b0);
        latch_window();
        @(negedge clk);
        check_val("frame_pending", frame_pending, 1);
        make_frame();
        send_frame(1'b0);  // Starts during the pending swap, so it is lost
        wait_swap_done();
        capture_check();
        show_frame(1'b0);
    endtask

    task automatic test_raster();
        int   n;
        int   run;
        int   lines;
        int   act_lines;
        logic prev_hs;
        logic prev_de;
        logic prev_vs;
        wait_vs_fall();
        if (aborted) return;
        n = 0;
        run = 0;
        lines = 0;
        act_lines = 0;
        prev_hs = vga_hs;
        prev_de = vga_de;
        prev_vs = vga_vs;
        @(negedge clk);
        while (!(prev_vs && !vga_vs)) begin
            if (n == TIMEOUT) begin
                timeout_hit("the next vertical sync");
                return;
            end
            if (prev_hs && !vga_hs) lines++;
            if (vga_de) begin
                run++;
            end else if (prev_de) begin
                check_val("vga_de pixels per line", run, WIN_W);
                act_lines++;
                run = 0;
            end
            prev_hs = vga_hs;
            prev_de = vga_de;
            prev_vs = vga_vs;
            n++;
            @(negedge clk);
        end
        check_val("vga_de active lines", act_lines, WIN_H);
        check_val("vga_hs lines per frame", lines, WIN_H + V_BLANK);
    endtask

    initial begin
        rst_n   = 1'b0;
        din     = 1'b0;
        din_vld = 1'b0;
        din_sop = 1'b0;
        din_eop = 1'b0;
        for (int r = 0; r < WIN_H; r++) begin
            for (int c = 0; c < WIN_W; c++) begin
                shown_win[r][c] = 1'b0;
            end
        end
        test_reset();
        show_frame(1'b0);  // Window crop
        show_frame(1'b1);  // Valid gaps
        test_drop();
        show_frame(1'b0);  // Ping-pong, frame D
        show_frame(1'b0);  // Ping-pong, frame E
        test_raster();
        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
verilog/frame_pkg.sv
verilog/scan_pkg.sv
verilog/pixel_mem_if.sv
verilog/window_writer.sv
verilog/pingpong_ram.sv
verilog/scan_reader.sv
verilog/frame_display_top.sv
bench/clk_gen.sv
bench/tb_frame_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the frame buffer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_frame_display -Mdir obj_dir

./obj_dir/Vtb_frame_display | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
